// File: verilog.f
+incdir+common
common/rv_decode_pkg.sv
decode/ctrl_decoder.sv
decode/alu_op_decoder.sv
decode/operand_select.sv
design/decode_stage.sv
test/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - common

sources:
  - files:
      - common/rv_decode_pkg.sv
      - decode/ctrl_decoder.sv
      - decode/alu_op_decoder.sv
      - decode/operand_select.sv
      - design/decode_stage.sv
  - target: test
    files:
      - test/tb_decode_stage.sv

// File: test/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OP  = 200;
    localparam int N_IMM = 200;
    localparam int N_LS  = 100;
    localparam int N_FWD = 60;
    localparam int N_BAD = 60;
    localparam int TEST_CYCLES = N_OP + N_IMM + N_LS + N_FWD + N_BAD + 6 * 3;  // 3 spare per test
    localparam int CYCLE_LIMIT = 5 + TEST_CYCLES + 20;

    // expected registered outputs, w is the source word for error lines
    typedef struct packed {
        logic [31:0] w;
        reg_addr_t   ra1;   // read port addresses, combinational
        reg_addr_t   ra2;
        reg_addr_t   rd;
        word_t       a;
        word_t       b;
        word_t       sd;
        alu_op_e     op;
        mem_op_e     mem;
        mem_size_e   size;
        logic        wb_alu;
        logic        wb_en;
        logic        ill;
    } exp_t;

    logic clk, arst_n, fwd_valid, wb_from_alu, wb_en, illegal_instr;
    logic [31:0] instr;
    reg_addr_t rs1_addr, rs2_addr, fwd_rd, rd_addr;
    word_t rs1_data, rs2_data, fwd_data, alu_a, alu_b, store_data;
    alu_op_e alu_op;
    mem_op_e mem_op;
    mem_size_e mem_size;

    word_t regs [32];            // register file model, x0 stays zero
    logic [31:0] rng_state = 32'h9d4d_498f;
    exp_t exp_next, exp_cur;     // next goes in at the driving edge, cur is checked
    logic issue_valid = 1'b0;
    logic chk_valid = 1'b0;
    int n_checks = 0, n_errors = 0, start_checks = 0, start_errors = 0, cycles = 0;

    assign rs1_data = regs[rs1_addr];  // combinational read port
    assign rs2_data = regs[rs2_addr];

    decode_stage dut_i (
        .clk (clk), .arst_n (arst_n), .instr (instr),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .fwd_valid (fwd_valid), .fwd_rd (fwd_rd), .fwd_data (fwd_data),
        .rd_addr (rd_addr), .alu_a (alu_a), .alu_b (alu_b), .alu_op (alu_op),
        .mem_op (mem_op), .mem_size (mem_size), .wb_from_alu (wb_from_alu),
        .wb_en (wb_en), .store_data (store_data), .illegal_instr (illegal_instr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic exp_t bubble_values();
        exp_t e;
        e = '0;
        e.op   = ALU_NOP;
        e.mem  = MEM_NOP;
        e.size = WORD;  // idle size is word, not zero
        return e;
    endfunction

    // source operand after forwarding, x0 never forwards
    function automatic word_t src_value(input reg_addr_t a, input logic fv,
                                        input reg_addr_t frd, input word_t fd);
        return (fv && frd == a && a != 5'd0) ? fd : regs[a];
    endfunction

    function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt, input logic is_op);
        case (f3)
            3'd0: return (alt && is_op) ? ALU_SUB : ALU_ADD;  // no SUBI
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return alt ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // expected registered outputs one cycle after w is presented
    function automatic exp_t ref_decode(input logic [31:0] w, input logic fv,
                                        input reg_addr_t frd, input word_t fd);
        exp_t e;
        logic [2:0] f3;
        word_t imm_i, imm_s, v1, v2;
        e = bubble_values();
        f3 = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        v1 = src_value(w[19:15], fv, frd, fd);
        v2 = src_value(w[24:20], fv, frd, fd);
        case (w[6:0])
            7'b000_0000: e.ill = 1'b0;  // bubble word
            7'b000_0011: begin          // loads
                if (f3 == 3'd3 || f3 >= 3'd6) begin
                    e.ill = 1'b1;
                end else begin
                    e.size = (f3 == 3'd0) ? BYTE_S : (f3 == 3'd1) ? HALF_S :
                             (f3 == 3'd2) ? WORD : (f3 == 3'd4) ? BYTE_U : HALF_U;
                    e.ra1 = w[19:15];
                    e.rd = w[11:7];
                    e.a = v1;
                    e.b = imm_i;
                    e.op = ALU_ADD;
                    e.mem = MEM_LOAD;
                    e.wb_en = 1'b1;  // data comes from memory, wb_alu low
                end
            end
            7'b010_0011: begin          // stores
                if (f3 >= 3'd3) begin
                    e.ill = 1'b1;
                end else begin
                    e.size = (f3 == 3'd0) ? BYTE_S : (f3 == 3'd1) ? HALF_S : WORD;
                    e.ra1 = w[19:15];
                    e.ra2 = w[24:20];
                    e.a = v1;
                    e.b = imm_s;
                    e.sd = v2;
                    e.op = ALU_ADD;
                    e.mem = MEM_STORE;
                end
            end
            7'b001_0011: begin          // OP-IMM, SLLI with bit 30 is not architectural
                if (f3 == 3'd1 && w[30]) begin
                    e.ill = 1'b1;
                end else begin
                    e.ra1 = w[19:15];
                    e.rd = w[11:7];
                    e.a = v1;
                    e.b = imm_i;
                    e.op = alu_map(f3, w[30], 1'b0);
                    e.wb_alu = 1'b1;
                    e.wb_en = 1'b1;
                end
            end
            7'b011_0011: begin          // OP
                e.ra1 = w[19:15];
                e.ra2 = w[24:20];
                e.rd = w[11:7];
                e.a = v1;
                e.b = v2;
                e.op = alu_map(f3, w[30], 1'b1);
                e.wb_alu = 1'b1;
                e.wb_en = 1'b1;
            end
            default: e.ill = 1'b1;
        endcase
        e.w = w;
        return e;
    endfunction

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] got,
                          input logic [31:0] w);
        $display("** Error %s: expected %h, actual %h (instr %h)", name, exp, got, w);
        n_errors++;
    endtask

    task automatic compare_outputs(input exp_t e);
        n_checks++;
        if (rd_addr !== e.rd) report("rd_addr", e.rd, rd_addr, e.w);
        if (alu_a !== e.a) report("alu_a", e.a, alu_a, e.w);
        if (alu_b !== e.b) report("alu_b", e.b, alu_b, e.w);
        if (store_data !== e.sd) report("store_data", e.sd, store_data, e.w);
        if (alu_op !== e.op) report("alu_op", e.op, alu_op, e.w);
        if (mem_op !== e.mem) report("mem_op", e.mem, mem_op, e.w);
        if (mem_size !== e.size) report("mem_size", e.size, mem_size, e.w);
        if (wb_from_alu !== e.wb_alu) report("wb_from_alu", e.wb_alu, wb_from_alu, e.w);
        if (wb_en !== e.wb_en) report("wb_en", e.wb_en, wb_en, e.w);
        if (illegal_instr !== e.ill) report("illegal_instr", e.ill, illegal_instr, e.w);
    endtask

    // unused sources must read x0
    task automatic compare_read_port(input exp_t e);
        if (rs1_addr !== e.ra1) report("rs1_addr", e.ra1, rs1_addr, e.w);
        if (rs2_addr !== e.ra2) report("rs2_addr", e.ra2, rs2_addr, e.w);
    endtask

    // expected value moves with the DUT register, checked half a cycle later
    always @(posedge clk) begin
        if (issue_valid) compare_read_port(exp_next);  // word still on instr here
        chk_valid <= issue_valid;
        exp_cur   <= exp_next;
    end

    always @(negedge clk) begin
        if (chk_valid) compare_outputs(exp_cur);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic issue(input logic [31:0] w, input logic fv, input reg_addr_t frd,
                         input word_t fd);
        @(negedge clk);
        instr = w;
        fwd_valid = fv;
        fwd_rd = frd;
        fwd_data = fd;
        exp_next = ref_decode(w, fv, frd, fd);
        issue_valid = 1'b1;
    endtask

    // idle one cycle so the last instruction gets compared, then report
    task automatic finish_test(input string name);
        @(negedge clk);
        instr = '0;
        fwd_valid = 1'b0;
        issue_valid = 1'b0;
        @(posedge clk);
        $display("test %s: %0d checked, %0d errors", name, n_checks - start_checks,
                 n_errors - start_errors);
        start_checks = n_checks;
        start_errors = n_errors;
    endtask

    task automatic op_test();
        logic [31:0] r;
        logic alt;
        for (int i = 0; i < N_OP; i++) begin
            r = rand32();
            alt = (i[2:0] == 3'd0 || i[2:0] == 3'd5) ? i[3] : 1'b0;  // SUB and SRA
            issue({1'b0, alt, 5'd0, r[4:0], r[9:5], i[2:0], r[14:10], 7'b011_0011}, 0, 0, 0);
        end
    endtask

    task automatic op_imm_test();
        logic [31:0] r;
        logic [11:0] imm;
        for (int i = 0; i < N_IMM; i++) begin
            r = rand32();
            imm = r[31:20];
            if (i[2:0] == 3'd1 || i[2:0] == 3'd5)
                imm[11:5] = i[3] ? 7'b010_0000 : 7'b000_0000;  // bad SLLI or SRAI
            issue({imm, r[4:0], i[2:0], r[9:5], 7'b001_0011}, 0, 0, 0);
        end
    endtask

    task automatic load_store_test();
        logic [31:0] r;
        logic [2:0] f3;
        for (int i = 0; i < N_LS; i++) begin
            r = rand32();
            if (i % 2 == 0) begin
                f3 = ((i / 2) % 5 < 3) ? 3'((i / 2) % 5) : 3'((i / 2) % 5 + 1);  // skip 011
                issue({r[31:15], f3, r[11:7], 7'b000_0011}, 0, 0, 0);
            end else begin
                f3 = 3'((i / 2) % 3);
                issue({r[31:15], f3, r[11:7], 7'b010_0011}, 0, 0, 0);
            end
        end
    endtask

    task automatic forwarding_test();
        logic [31:0] r;
        reg_addr_t rs1, rs2, frd;
        logic fv;
        for (int i = 0; i < N_FWD; i++) begin
            r = rand32();
            rs1 = {1'b0, r[3:0]} | 5'd1;    // odd, 1..15
            rs2 = {1'b1, r[7:4]};           // 16..31
            fv = 1'b1;
            case (i % 6)
                0: frd = rs1;
                1: frd = rs2;
                2: begin
                    rs2 = rs1;
                    frd = rs1;
                end
                3: frd = {1'b0, r[11:8]} & 5'b11110;  // even, hits neither
                4: begin
                    rs1 = '0;
                    rs2 = '0;
                    frd = '0;
                end
                default: begin
                    frd = rs1;
                    fv = 1'b0;
                end
            endcase
            if ((i / 6) % 2 == 1)
                issue({r[31:25], rs2, rs1, 3'd2, r[11:7], 7'b010_0011}, fv, frd, rand32());
            else
                issue({7'd0, rs2, rs1, r[14:12], r[11:7], 7'b011_0011}, fv, frd, rand32());
        end
    endtask

    task automatic bubble_illegal_test();
        logic [31:0] r, w;
        logic [6:0] opc;
        logic [2:0] f3;
        for (int i = 0; i < N_BAD; i++) begin
            r = rand32();
            w = rand32();
            case (i % 3)
                0: w = '0;
                1: begin
                    opc = w[6:0];
                    if (opc == 7'h00 || opc == 7'h03 || opc == 7'h13 || opc == 7'h23 ||
                        opc == 7'h33) opc = opc ^ 7'h40;  // move off supported groups
                    w[6:0] = opc;
                end
                default: begin
                    if (r[7]) begin
                        f3 = (r[9:8] == 2'd0) ? 3'd3 : r[8] ? 3'd6 : 3'd7;
                        w[6:0] = 7'b000_0011;
                    end else begin
                        f3 = (r[10:8] < 3'd3) ? r[10:8] + 3'd3 : r[10:8];
                        w[6:0] = 7'b010_0011;
                    end
                    w[14:12] = f3;
                end
            endcase
            issue(w, r[0], r[5:1], rand32());
        end
    endtask

    initial begin
        arst_n = 1'b0;
        instr = '0;
        fwd_valid = 1'b0;
        fwd_rd = '0;
        fwd_data = '0;
        exp_next = bubble_values();
        regs[0] = '0;
        for (int k = 1; k < 32; k++) regs[k] = rand32();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        compare_outputs(bubble_values());  // nothing clocked in yet
        finish_test("reset state");
        op_test();
        finish_test("op group");
        op_imm_test();
        finish_test("op-imm group");
        load_store_test();
        finish_test("loads and stores");
        forwarding_test();
        finish_test("forwarding");
        bubble_illegal_test();
        finish_test("bubble and illegal words");
        $display("done: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`default_nettype none

`include "decode_settings.svh"

module decode_stage import rv_decode_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [`INSTR_W-1:0] instr,
    // register file read port
    output reg_addr_t          rs1_addr,     // combinational
    output reg_addr_t          rs2_addr,
    input  word_t              rs1_data,
    input  word_t              rs2_data,
    // forwarding from the following stage
    input  logic               fwd_valid,
    input  reg_addr_t          fwd_rd,
    input  word_t              fwd_data,
    // registered towards execute
    output reg_addr_t          rd_addr,
    output word_t              alu_a,
    output word_t              alu_b,
    output alu_op_e            alu_op,
    output mem_op_e            mem_op,
    output mem_size_e          mem_size,
    output logic               wb_from_alu,
    output logic               wb_en,
    output word_t              store_data,
    output logic               illegal_instr
);

    // next values, one decode per cycle
    reg_addr_t rd_addr_d;
    opcode_e   group;
    logic      imm_is_store;
    logic      b_is_imm;
    mem_op_e   mem_op_d;
    mem_size_e mem_size_d;
    logic      wb_from_alu_d;
    logic      wb_en_d;
    logic      illegal_d;
    alu_op_e   alu_op_d;
    logic      alu_legal;
    word_t     alu_a_d;
    word_t     alu_b_d;
    word_t     store_data_d;
    logic      kill;            // nothing useful decoded, clear the payload

    ctrl_decoder ctrl_i (
        .instr         (instr),
        .alu_legal     (alu_legal),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd_addr       (rd_addr_d),
        .group         (group),
        .imm_is_store  (imm_is_store),
        .b_is_imm      (b_is_imm),
        .mem_op        (mem_op_d),
        .mem_size      (mem_size_d),
        .wb_from_alu   (wb_from_alu_d),
        .wb_en         (wb_en_d),
        .illegal_instr (illegal_d)
    );

    alu_op_decoder alu_dec_i (
        .group     (group),
        .funct3    (instr[`FUNCT3_LSB +: `FUNCT3_W]),
        .bit30     (instr[`ALT_BIT]),
        .alu_op    (alu_op_d),
        .alu_legal (alu_legal)
    );

    operand_select opsel_i (
        .instr        (instr),
        .imm_is_store (imm_is_store),
        .b_is_imm     (b_is_imm),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .fwd_valid    (fwd_valid),
        .fwd_rd       (fwd_rd),
        .fwd_data     (fwd_data),
        .alu_a        (alu_a_d),
        .alu_b        (alu_b_d),
        .store_data   (store_data_d)
    );

    // controls are already bubbled by the decoders, operands still follow the regfile
    assign kill = illegal_d || (group == OPC_BUBBLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_addr       <= '0;
            alu_a         <= '0;
            alu_b         <= '0;
            alu_op        <= ALU_NOP;
            mem_op        <= MEM_NOP;
            mem_size      <= WORD;
            wb_from_alu   <= 1'b0;
            wb_en         <= 1'b0;
            store_data    <= '0;
            illegal_instr <= 1'b0;
        end else begin
            rd_addr       <= rd_addr_d;
            alu_op        <= alu_op_d;
            mem_op        <= mem_op_d;
            mem_size      <= mem_size_d;
            wb_from_alu   <= wb_from_alu_d;
            wb_en         <= wb_en_d;
            illegal_instr <= illegal_d;   // flag travels with the bubble
            alu_a         <= kill ? '0 : alu_a_d;
            alu_b         <= kill ? '0 : alu_b_d;
            store_data    <= store_data_d;  // zero unless a legal store
        end
    end

endmodule

`default_nettype wire

// File: decode/operand_select.sv
`default_nettype none

`include "decode_settings.svh"

module operand_select import rv_decode_pkg::*; (
    input  word_t     instr,
    input  logic      imm_is_store,  // pick S-imm, also marks a store for store_data
    input  logic      b_is_imm,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  word_t     rs1_data,      // register file read data, same cycle
    input  word_t     rs2_data,
    input  logic      fwd_valid,     // later stage writes fwd_rd this cycle
    input  reg_addr_t fwd_rd,
    input  word_t     fwd_data,
    output word_t     alu_a,
    output word_t     alu_b,
    output word_t     store_data
);

    word_t imm_i;
    word_t imm_s;
    word_t imm;
    logic  fwd_hit_rs1;
    logic  fwd_hit_rs2;
    word_t rs1_val;
    word_t rs2_val;

    // I-type: imm[11:0] = instr[31:20]
    assign imm_i = {{(`XLEN-`IMM_W){instr[`INSTR_W-1]}}, instr[`IMM_I_LSB +: `IMM_W]};

    // S-type: imm[11:5] = instr[31:25], imm[4:0] = instr[11:7]
    assign imm_s = {{(`XLEN-`IMM_W){instr[`INSTR_W-1]}},
                    instr[`FUNCT7_LSB +: `FUNCT7_W],
                    instr[`RD_LSB +: `REG_ADDR_W]};

    assign imm = imm_is_store ? imm_s : imm_i;

    // x0 never forwards, it is hardwired zero in the register file
    assign fwd_hit_rs1 = fwd_valid && (fwd_rd == rs1_addr) && (rs1_addr != '0);
    assign fwd_hit_rs2 = fwd_valid && (fwd_rd == rs2_addr) && (rs2_addr != '0);

    assign rs1_val = fwd_hit_rs1 ? fwd_data : rs1_data;
    assign rs2_val = fwd_hit_rs2 ? fwd_data : rs2_data;

    assign alu_a      = rs1_val;
    assign alu_b      = b_is_imm ? imm : rs2_val;  // loads, stores and OP-IMM use the immediate
    assign store_data = imm_is_store ? rs2_val : '0;  // only stores carry data forward

endmodule

`default_nettype wire

// File: decode/alu_op_decoder.sv
`default_nettype none

`include "decode_settings.svh"

module alu_op_decoder import rv_decode_pkg::*; (
    input  opcode_e              group,
    input  logic [`FUNCT3_W-1:0] funct3,
    input  logic                 bit30,      // funct7[5]
    output alu_op_e              alu_op,
    output logic                 alu_legal
);

    always_comb begin
        alu_op    = ALU_NOP;
        alu_legal = 1'b1;

        case (group)
            OPC_LOAD, OPC_STORE: alu_op = ALU_ADD;  // address = base + offset
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    3'b000: begin
                        // SUB exists only in the register form, ADDI ignores bit 30
                        alu_op = (bit30 && group == OPC_OP) ? ALU_SUB : ALU_ADD;
                    end
                    3'b001: begin
                        alu_op = ALU_SLL;
                        // SLLI has funct7 all zero, only bit 30 is visible here
                        if (group == OPC_OP_IMM && bit30) begin
                            alu_legal = 1'b0;
                        end
                    end
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = bit30 ? ALU_SRA : ALU_SRL;  // both forms
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: alu_op = ALU_NOP;
                endcase
                if (!alu_legal) begin
                    alu_op = ALU_NOP;  // illegal shift leaves no operation behind
                end
            end
            default: alu_op = ALU_NOP;  // bubble and unknown groups
        endcase
    end

endmodule

`default_nettype wire

// File: decode/ctrl_decoder.sv
`default_nettype none

`include "decode_settings.svh"

module ctrl_decoder import rv_decode_pkg::*; (
    input  word_t     instr,
    input  logic      alu_legal,      // from alu_op_decoder, only meaningful for OP / OP-IMM
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output opcode_e   group,          // recognised group, BUBBLE if nothing usable
    output logic      imm_is_store,   // S-imm instead of I-imm
    output logic      b_is_imm,       // ALU operand B from immediate
    output mem_op_e   mem_op,
    output mem_size_e mem_size,
    output logic      wb_from_alu,    // write-back source: 1 = ALU, 0 = memory
    output logic      wb_en,
    output logic      illegal_instr
);

    logic [`FUNCT3_W-1:0] funct3;
    reg_addr_t            rs1_field;
    reg_addr_t            rs2_field;
    reg_addr_t            rd_field;

    assign funct3    = instr[`FUNCT3_LSB +: `FUNCT3_W];
    assign rs1_field = instr[`RS1_LSB +: `REG_ADDR_W];
    assign rs2_field = instr[`RS2_LSB +: `REG_ADDR_W];
    assign rd_field  = instr[`RD_LSB +: `REG_ADDR_W];

    always_comb begin
        // bubble values unless a legal group fills them in
        rs1_addr      = '0;
        rs2_addr      = '0;
        rd_addr       = '0;
        group         = OPC_BUBBLE;
        imm_is_store  = 1'b0;
        b_is_imm      = 1'b0;
        mem_op        = MEM_NOP;
        mem_size      = WORD;
        wb_from_alu   = 1'b0;
        wb_en         = 1'b0;
        illegal_instr = 1'b0;

        case (instr[`OPCODE_W-1:0])
            OPC_LOAD: begin
                case (funct3)
                    3'b000: mem_size = BYTE_S;  // LB
                    3'b001: mem_size = HALF_S;  // LH
                    3'b010: mem_size = WORD;    // LW
                    3'b100: mem_size = BYTE_U;  // LBU
                    3'b101: mem_size = HALF_U;  // LHU
                    default: illegal_instr = 1'b1;
                endcase
                if (!illegal_instr) begin
                    group    = OPC_LOAD;
                    rs1_addr = rs1_field;      // base address
                    rd_addr  = rd_field;
                    b_is_imm = 1'b1;           // base + I-imm
                    mem_op   = MEM_LOAD;
                    wb_en    = 1'b1;           // wb_from_alu stays low, data comes from memory
                end
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000: mem_size = BYTE_S; // SB
                    3'b001: mem_size = HALF_S; // SH
                    3'b010: mem_size = WORD;   // SW
                    default: illegal_instr = 1'b1;
                endcase
                if (!illegal_instr) begin
                    group        = OPC_STORE;
                    rs1_addr     = rs1_field;  // base address
                    rs2_addr     = rs2_field;  // store data source
                    imm_is_store = 1'b1;
                    b_is_imm     = 1'b1;
                    mem_op       = MEM_STORE;
                end
            end
            OPC_OP_IMM: begin
                // group goes out regardless so the ALU decoder can judge the shift encoding
                group = OPC_OP_IMM;
                if (alu_legal) begin
                    rs1_addr    = rs1_field;
                    rd_addr     = rd_field;
                    b_is_imm    = 1'b1;
                    wb_from_alu = 1'b1;
                    wb_en       = 1'b1;
                end else begin
                    illegal_instr = 1'b1;
                end
            end
            OPC_OP: begin
                group = OPC_OP;
                if (alu_legal) begin
                    rs1_addr    = rs1_field;
                    rs2_addr    = rs2_field;
                    rd_addr     = rd_field;
                    wb_from_alu = 1'b1;
                    wb_en       = 1'b1;
                end else begin
                    illegal_instr = 1'b1;
                end
            end
            OPC_BUBBLE: begin
                // all-zero word, defaults already describe a bubble
            end
            default: illegal_instr = 1'b1;  // JAL, branches, LUI, FENCE, SYSTEM, junk
        endcase
    end

endmodule

`default_nettype wire

// File: common/rv_decode_pkg.sv
`default_nettype none

`include "decode_settings.svh"

package rv_decode_pkg;

    typedef logic [`XLEN-1:0]       word_t;      // one data word
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // register index

    // instruction groups handled by the decode stage
    typedef enum logic [`OPCODE_W-1:0] {
        OPC_BUBBLE = 7'b000_0000,  // all-zero word, pipeline bubble
        OPC_LOAD   = 7'b000_0011,  // LB, LH, LW, LBU, LHU
        OPC_OP_IMM = 7'b001_0011,  // ADDI .. SRAI
        OPC_STORE  = 7'b010_0011,  // SB, SH, SW
        OPC_OP     = 7'b011_0011   // ADD .. AND
    } opcode_e;

    // ALU operations, NOP must stay at 0 so a cleared register is a bubble
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_e;

    // what the memory stage does with this instruction
    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // access size, loads also carry sign handling for write-back
    typedef enum logic [2:0] {
        BYTE_S = 3'd0,  // LB / SB
        HALF_S = 3'd1,  // LH / SH
        WORD   = 3'd2,  // LW / SW, also the idle value
        BYTE_U = 3'd3,  // LBU
        HALF_U = 3'd4   // LHU
    } mem_size_e;

endpackage

`default_nettype wire

// File: common/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// datapath widths
`define XLEN        32  // data word
`define REG_ADDR_W  5   // x0..x31
`define ALU_OP_W    4   // alu_op_e encoding width
`define INSTR_W     32  // fixed-length RV32I words only

// instruction field positions (RV32I base formats)
`define OPCODE_W    7   // opcode sits at [6:0]
`define RD_LSB      7   // rd, also S-imm[4:0]
`define FUNCT3_LSB  12
`define FUNCT3_W    3
`define RS1_LSB     15
`define RS2_LSB     20
`define FUNCT7_LSB  25  // funct7, also S-imm[11:5]
`define FUNCT7_W    7

// immediates
`define IMM_I_LSB   20  // I-imm[11:0] lives in [31:20]
`define IMM_W       12  // both I and S immediates are 12 bits before extension

// bit 30 picks SUB/SRA over ADD/SRL
`define ALT_BIT     30

`endif
